// File: filelist.f
logic/cpu_types_pkg.sv
logic/dcache_array.sv
logic/dcache.sv
logic/memory_control.sv
logic/ram.sv
logic/memory_subsystem.sv
testbench/tb_memory_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the memory subsystem testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_memory_subsystem
BIN="obj_dir/V${TOP}"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module "${TOP}" --Mdir obj_dir -o "V${TOP}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "verilator build error, status ${status}"
  exit 1
fi

output=$("./${BIN}" 2>&1)
status=$?
printf '%s\n' "${output}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

# the run counts as good only if the pass line was printed
if printf '%s\n' "${output}" | grep -qx "test passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/tb_memory_subsystem.sv
// memory subsystem testbench driving random datapath traffic against a flat memory model
`timescale 1ns/100ps
`default_nettype none

module tb_memory_subsystem;
  import cpu_types_pkg::*;

  localparam int RAM_WAIT   = 2;
  localparam int CLK_PERIOD = 20;
  localparam int N_RAW      = 16;   // write then read pairs
  localparam int N_RAND     = 240;  // mixed random accesses
  localparam int N_LRU      = 8;    // accesses in the lru test
  localparam int N_HALT_WR  = 24;   // writes before halt
  localparam int HOLD_CYC   = 6;    // cycles halt stays high after flushed
  // worst case bounds in cycles
  localparam int XFER_CYC   = RAM_WAIT + 3;  // request edge, stb cycles and ack
  localparam int MISS_CYC   = 4 * XFER_CYC + 3;  // two writebacks, two fetches, install, hit
  localparam int FLUSH_CYC  = 2 * DSETS * (2 * XFER_CYC + 1) + 4;
  localparam int N_REQ      = 2 * N_RAW + N_RAND + N_LRU + N_HALT_WR + 256;
  localparam int WATCHDOG_NS = (N_REQ * MISS_CYC + FLUSH_CYC + HOLD_CYC + 200) * CLK_PERIOD;

  logic  CLK;
  logic  nRST;
  logic  dmemREN;
  logic  dmemWEN;
  logic  halt;
  word_t dmemaddr;
  word_t dmemstore;
  word_t dmemload;
  logic  dhit;
  logic  flushed;

  word_t model [256];     // flat word addressed memory
  logic  written [256];   // words stored at least once
  logic  blk_seen [128];  // blocks touched since the flush
  word_t rng_state;
  int    n_tests, n_checks, n_errors;
  int    chk_start, err_start;

  memory_subsystem #(
    .RAM_WAIT (RAM_WAIT)
  ) u_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .flushed   (flushed)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // hard stop if some handshake never completes
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: no progress within %0d ns, a request or the flush never completed",
             WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // byte address from tag, set and word in block
  function automatic word_t make_addr(input int unsigned tag, input int unsigned set,
                                      input int unsigned wrd);
    return word_t'((tag << 6) | (set << 3) | (wrd << 2));
  endfunction

  // one of three tags per set (0, 5 or 10) inside 256 words
  function automatic word_t pick_addr();
    word_t       r;
    int unsigned tsel;
    r    = next_rand();
    tsel = int'(r[9:8]) % 3;
    return make_addr(5 * tsel, int'(r[2:0]), int'(r[3]));
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic begin_test();
    chk_start = n_checks;
    err_start = n_errors;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("%-24s done, %0d checks, %0d errors", name,
             n_checks - chk_start, n_errors - err_start);
  endtask

  // holds the request from a falling edge until dhit at a rising edge
  task automatic issue_request(input logic we, input word_t addr, input word_t data,
                               output logic first_hit, output word_t rdata);
    dmemaddr  = addr;
    dmemstore = data;
    dmemWEN   = we;
    dmemREN   = !we;
    #1;
    first_hit = dhit;  // hit or miss as seen in the first cycle
    while (!dhit) begin
      @(negedge CLK);
      #1;
    end
    rdata = dmemload;
    @(posedge CLK);    // request retires on this edge
    @(negedge CLK);
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  task automatic read_word(input word_t addr, output logic first_hit);
    word_t rdata;
    issue_request(1'b0, addr, '0, first_hit, rdata);
    check_value($sformatf("dmemload @%h", addr), rdata, model[addr[9:2]]);
  endtask

  task automatic write_word(input word_t addr, input word_t data, output logic first_hit);
    word_t rdata;
    issue_request(1'b1, addr, data, first_hit, rdata);
    model[addr[9:2]]   = data;
    written[addr[9:2]] = 1'b1;
  endtask

  initial begin
    logic  fh;
    word_t a, b, c, addr;
    int    set;

    // every dut input known from time zero
    nRST      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    halt      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    rng_state = 32'h759d_eafa;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;
    for (int i = 0; i < 256; i++) begin
      model[i]   = '0;
      written[i] = 1'b0;
    end
    for (int i = 0; i < 128; i++)
      blk_seen[i] = 1'b0;

    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    // quiet outputs after reset
    begin_test();
    #1;
    check_value("flushed", word_t'(flushed), 32'd0);
    check_value("dhit", word_t'(dhit), 32'd0);
    finish_test("reset state");

    // freshly written word hits and reads back
    begin_test();
    @(negedge CLK);
    for (int i = 0; i < N_RAW; i++) begin
      addr = pick_addr();
      write_word(addr, next_rand(), fh);
      read_word(addr, fh);
      check_value($sformatf("dhit @%h", addr), word_t'(fh), 32'd1);
    end
    finish_test("read after write");

    // random mix where the third tag forces dirty evictions
    begin_test();
    for (int i = 0; i < N_RAND; i++) begin
      addr = pick_addr();
      if (next_rand() & 32'h1)
        write_word(addr, next_rand(), fh);
      else
        read_word(addr, fh);
    end
    finish_test("random traffic");

    // lru victim choice in one set
    begin_test();
    set = int'(next_rand() & 32'h7);
    a   = make_addr(0, set, 0);
    b   = make_addr(5, set, 0);
    c   = make_addr(10, set, 0);
    read_word(a, fh);
    read_word(b, fh);
    read_word(a, fh);
    read_word(b, fh);         // a now least recently used
    read_word(c, fh);
    check_value("dhit first cycle, third tag", word_t'(fh), 32'd0);
    read_word(b, fh);         // b stays while c becomes lru
    check_value("dhit first cycle, mru tag", word_t'(fh), 32'd1);
    read_word(a, fh);         // a was evicted by c
    check_value("dhit first cycle, evicted tag", word_t'(fh), 32'd0);
    finish_test("lru eviction");

    // flush on halt
    begin_test();
    for (int i = 0; i < N_HALT_WR; i++)
      write_word(pick_addr(), next_rand(), fh);
    halt = 1'b1;
    #1;
    while (!flushed) begin
      @(negedge CLK);
      #1;
    end
    repeat (HOLD_CYC) begin
      @(negedge CLK);
      #1;
      check_value("flushed while halt", word_t'(flushed), 32'd1);
    end
    @(negedge CLK);
    halt = 1'b0;
    #1;
    check_value("flushed before idle", word_t'(flushed), 32'd1);  // leaves on next edge
    @(negedge CLK);
    #1;
    check_value("flushed after release", word_t'(flushed), 32'd0);
    finish_test("halt flush");

    // everything written must come back from ram into an empty cache
    begin_test();
    @(negedge CLK);
    for (int i = 0; i < 256; i++) begin
      if (written[i]) begin
        addr = word_t'(i << 2);
        read_word(addr, fh);
        if (!blk_seen[addr[9:3]])  // sibling word of a fetched block may hit
          check_value($sformatf("dhit first read @%h", addr), word_t'(fh), 32'd0);
        blk_seen[addr[9:3]] = 1'b1;
      end
    end
    finish_test("readback after flush");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/memory_subsystem.sv
// memory subsystem top: data cache, memory controller and wishbone ram
`timescale 1ns/100ps
`default_nettype none

module memory_subsystem #(
  parameter int unsigned RAM_WAIT = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dmemREN,
  input  logic                  dmemWEN,
  input  cpu_types_pkg::word_t  dmemaddr,
  input  cpu_types_pkg::word_t  dmemstore,
  input  logic                  halt,
  output cpu_types_pkg::word_t  dmemload,
  output logic                  dhit,
  output logic                  flushed
);
  import cpu_types_pkg::*;

  // dcache to controller
  logic  dREN, dWEN, dwait;
  word_t daddr, dstore, dload;
  // controller to ram, wishbone classic
  logic  wb_cyc, wb_stb, wb_we, wb_ack;
  word_t wb_adr, wb_dat_w, wb_dat_r;

  dcache u_dcache (
    .CLK       (CLK),
    .nRST      (nRST),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .halt      (halt),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .flushed   (flushed),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .daddr     (daddr),
    .dstore    (dstore),
    .dload     (dload),
    .dwait     (dwait)
  );

  memory_control u_memory_control (
    .CLK      (CLK),
    .nRST     (nRST),
    .dREN     (dREN),
    .dWEN     (dWEN),
    .daddr    (daddr),
    .dstore   (dstore),
    .dload    (dload),
    .dwait    (dwait),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  ram #(
    .RAM_WAIT (RAM_WAIT)
  ) u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

endmodule

`default_nettype wire

// File: logic/ram.sv
// wishbone classic slave ram, 256 words, fixed wait states before ack
`timescale 1ns/100ps
`default_nettype none

module ram #(
  parameter int unsigned RAM_WAIT = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  cpu_types_pkg::word_t  wb_adr,
  input  cpu_types_pkg::word_t  wb_dat_w,
  output cpu_types_pkg::word_t  wb_dat_r,
  output logic                  wb_ack
);
  import cpu_types_pkg::*;

  localparam int WORDS = 256;
  localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

  word_t            mem [WORDS];
  logic [7:0]       word_idx;  // word address
  logic [CNT_W-1:0] wait_cnt;  // stb cycles seen so far
  logic             pending;   // addressed, ack not given yet

  assign word_idx = wb_adr[9:2];
  assign pending  = wb_cyc && wb_stb && !wb_ack;

  initial begin
    for (int i = 0; i < WORDS; i++)
      mem[i] = '0;
  end

  // ack after RAM_WAIT+1 stb cycles, one cycle wide
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
      wb_ack   <= 1'b0;
    end else begin
      wb_ack <= pending && (wait_cnt == CNT_W'(RAM_WAIT));
      if (pending && (wait_cnt != CNT_W'(RAM_WAIT)))
        wait_cnt <= wait_cnt + 1'b1;
      else
        wait_cnt <= '0;
    end
  end

  // store on the ack edge
  always_ff @(posedge CLK) begin
    if (wb_ack && wb_we)
      mem[word_idx] <= wb_dat_w;
  end

  assign wb_dat_r = mem[word_idx];  // sampled by the master with ack

  assert property (@(posedge CLK) disable iff (!nRST) wb_ack |-> wb_cyc && wb_stb)
    else $error("ram ack outside a strobed cycle");

endmodule

`default_nettype wire

// File: logic/memory_control.sv
// memory controller turning dcache word requests into wishbone classic master cycles
`timescale 1ns/100ps
`default_nettype none

module memory_control (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dREN,
  input  logic                  dWEN,
  input  cpu_types_pkg::word_t  daddr,
  input  cpu_types_pkg::word_t  dstore,
  output cpu_types_pkg::word_t  dload,
  output logic                  dwait,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output cpu_types_pkg::word_t  wb_adr,
  output cpu_types_pkg::word_t  wb_dat_w,
  input  cpu_types_pkg::word_t  wb_dat_r,
  input  logic                  wb_ack
);

  logic req_any;
  logic start;  // open a new bus cycle this edge

  assign req_any = dREN | dWEN;
  assign start   = !wb_cyc && req_any;

  // cyc drops on the ack edge so the next word starts its own cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else if (wb_cyc) begin
      if (wb_ack) begin
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
      end
    end else if (req_any) begin
      wb_cyc <= 1'b1;  // cyc and stb together
      wb_stb <= 1'b1;
      wb_we  <= dWEN;
    end
  end

  // address and write data latched once per cycle
  always_ff @(posedge CLK) begin
    if (start) begin
      wb_adr   <= daddr;
      wb_dat_w <= dstore;
    end
  end

  assign dload = wb_dat_r;             // valid with ack
  assign dwait = !(wb_cyc && wb_ack);  // only ack releases the dcache

  assert property (@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc)
    else $error("wishbone stb without cyc");

endmodule

`default_nettype wire

// File: logic/dcache.sv
// dcache controller: hit path, lru writeback and refill, flush on halt
`timescale 1ns/100ps
`default_nettype none

module dcache (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  dmemREN,
  input  logic                  dmemWEN,
  input  logic                  halt,
  input  cpu_types_pkg::word_t  dmemaddr,
  input  cpu_types_pkg::word_t  dmemstore,
  output cpu_types_pkg::word_t  dmemload,
  output logic                  dhit,
  output logic                  flushed,
  output logic                  dREN,
  output logic                  dWEN,
  output cpu_types_pkg::word_t  daddr,
  output cpu_types_pkg::word_t  dstore,
  input  cpu_types_pkg::word_t  dload,
  input  logic                  dwait
);
  import cpu_types_pkg::*;

  typedef enum logic [3:0] {
    idle, wb_word0, wb_word1, fetch_word0, fetch_word1, install,
    flush_scan, flush_wb0, flush_wb1, flush_done
  } state_t;

  state_t                state, next_state;
  dcachef_t              req;        // datapath address by field
  logic                  req_any;
  logic [DIDX_W-1:0]     arr_idx;
  logic                  hit, hit_way, lru_way;
  dframe_t               victim, frame_rd, wr_frame, merged;
  logic                  wr_en, wr_way, touch, touch_way;
  logic [DIDX_W:0]       flush_cnt;  // {set, step}, two steps per set
  logic                  flush_last;
  logic                  retire;     // flush step done, drop the line
  logic                  in_flush;
  logic                  wsel;       // word of the block on the bus
  logic [DTAG_W-1:0]     bus_tag;
  word_t [2**DBLK_W-1:0] fill;       // refill buffer

  assign req      = dcachef_t'(dmemaddr);
  assign req_any  = dmemREN | dmemWEN;
  assign in_flush = state inside {flush_scan, flush_wb0, flush_wb1};
  assign arr_idx  = in_flush ? flush_cnt[DIDX_W:1] : req.idx;

  dcache_array u_dcache_array (
    .CLK       (CLK),
    .nRST      (nRST),
    .idx       (arr_idx),
    .tag       (req.tag),
    .hit       (hit),
    .hit_way   (hit_way),
    .lru_way   (lru_way),
    .victim    (victim),
    .frame_rd  (frame_rd),
    .wr_en     (wr_en),
    .wr_way    (wr_way),
    .wr_frame  (wr_frame),
    .touch     (touch),
    .touch_way (touch_way)
  );

  // datapath side
  assign dhit     = (state == idle) && req_any && hit;  // no hit while a miss is open
  assign dmemload = frame_rd.data[req.blkoff];
  assign flushed  = (state == flush_done);

  // write hit, new word into the hit line and mark it dirty
  always_comb begin
    merged                   = frame_rd;
    merged.data[req.blkoff]  = dmemstore;
    merged.dirty             = 1'b1;
  end

  // memory side, block address from tag, set and word select
  assign dREN       = state inside {fetch_word0, fetch_word1};
  assign dWEN       = state inside {wb_word0, wb_word1, flush_wb0, flush_wb1};
  assign wsel       = state inside {wb_word1, fetch_word1, flush_wb1};
  assign bus_tag    = dWEN ? victim.tag : req.tag;  // writeback goes to the old line
  assign daddr      = {bus_tag, arr_idx, wsel, {DBYT_W{1'b0}}};
  assign dstore     = victim.data[wsel];
  assign flush_last = &flush_cnt;

  always_comb begin
    next_state = state;
    wr_en      = 1'b0;
    wr_way     = lru_way;  // refill and flush both work on the victim
    wr_frame   = merged;
    touch      = 1'b0;
    touch_way  = lru_way;
    retire     = 1'b0;
    case (state)
      idle: begin
        if (dhit) begin
          touch     = 1'b1;
          touch_way = hit_way;
          if (dmemWEN) begin
            wr_en  = 1'b1;
            wr_way = hit_way;
          end
        end
        if (halt)
          next_state = flush_scan;  // halt wins over a pending miss
        else if (req_any && !hit)
          next_state = (victim.valid && victim.dirty) ? wb_word0 : fetch_word0;
      end
      wb_word0:    if (!dwait) next_state = wb_word1;
      wb_word1:    if (!dwait) next_state = fetch_word0;
      fetch_word0: if (!dwait) next_state = fetch_word1;
      fetch_word1: if (!dwait) next_state = install;
      install: begin
        wr_en      = 1'b1;
        wr_frame   = '{tag: req.tag, data: fill, valid: 1'b1, dirty: 1'b0};
        next_state = idle;  // hits next cycle
      end
      // victim walk, touching the victim flips lru so step 1 sees the other way
      flush_scan: begin
        if (victim.valid && victim.dirty)
          next_state = flush_wb0;
        else
          retire = 1'b1;
      end
      flush_wb0:  if (!dwait) next_state = flush_wb1;
      flush_wb1:  if (!dwait) retire = 1'b1;
      flush_done: if (!halt) next_state = idle;
      default:    next_state = idle;
    endcase
    if (retire) begin
      wr_en      = 1'b1;
      wr_frame   = '0;  // invalid and clean
      touch      = 1'b1;
      next_state = flush_last ? flush_done : flush_scan;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= idle;
      flush_cnt <= '0;
    end else begin
      state <= next_state;
      if (retire)
        flush_cnt <= flush_cnt + 1'b1;  // wraps back to 0 after the last step
    end
  end

  // refill words as they arrive
  always_ff @(posedge CLK) begin
    if (dREN && !dwait)
      fill[wsel] <= dload;
  end

  assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
    else $error("dcache drives dREN and dWEN together");

  // a transfer keeps its address until memory_control completes it
  assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(daddr))
    else $error("dcache changed daddr during a waiting transfer");

endmodule

`default_nettype wire

// File: logic/dcache_array.sv
// dcache storage: two ways of eight frames, tag compare, victim select and lru bits
`timescale 1ns/100ps
`default_nettype none

module dcache_array (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic [cpu_types_pkg::DIDX_W-1:0]  idx,
  input  logic [cpu_types_pkg::DTAG_W-1:0]  tag,
  output logic                              hit,
  output logic                              hit_way,
  output logic                              lru_way,
  output cpu_types_pkg::dframe_t            victim,
  output cpu_types_pkg::dframe_t            frame_rd,
  input  logic                              wr_en,
  input  logic                              wr_way,
  input  cpu_types_pkg::dframe_t            wr_frame,
  input  logic                              touch,
  input  logic                              touch_way
);
  import cpu_types_pkg::*;

  dframe_t [DSETS-1:0][1:0] frames;  // [set][way]
  logic    [DSETS-1:0]      lru;     // per set, the way to evict next
  logic                     match0;
  logic                     match1;

  // tag compare on both ways of the addressed set
  assign match0 = frames[idx][0].valid && (frames[idx][0].tag == tag);
  assign match1 = frames[idx][1].valid && (frames[idx][1].tag == tag);

  assign hit     = match0 | match1;
  assign hit_way = match1;            // way 0 when neither matches
  assign lru_way = lru[idx];

  // read ports
  assign frame_rd = frames[idx][hit_way];  // line the datapath reads or merges into
  assign victim   = frames[idx][lru_way];  // line a miss or a flush step works on

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      frames <= '0;  // all lines invalid and clean
      lru    <= '0;
    end else begin
      if (wr_en)
        frames[idx][wr_way] <= wr_frame;  // whole frame at once
      // used way becomes mru, so the other one is next out
      if (touch)
        lru[idx] <= ~touch_way;
    end
  end

  // a block may live in only one way of its set
  for (genvar s = 0; s < DSETS; s++) begin : g_dup_chk
    assert property (@(posedge CLK) disable iff (!nRST)
      !(frames[s][0].valid && frames[s][1].valid &&
        (frames[s][0].tag == frames[s][1].tag)))
      else $error("dcache set %0d holds the same tag in both ways", s);
  end

endmodule

`default_nettype wire

// File: logic/cpu_types_pkg.sv
// cpu types package: data word, cache address view and cache frame layout
`default_nettype none

package cpu_types_pkg;

  // datapath word
  typedef logic [31:0] word_t;

  // dcache geometry, 2 way, 8 sets, 2 word blocks
  localparam int DTAG_W = 26;  // tag bits
  localparam int DIDX_W = 3;   // set index bits
  localparam int DBLK_W = 1;   // word within block
  localparam int DBYT_W = 2;   // byte within word
  localparam int DSETS  = 8;   // sets per way

  // byte address split for dcache lookup
  typedef struct packed {
    logic [DTAG_W-1:0] tag;
    logic [DIDX_W-1:0] idx;
    logic [DBLK_W-1:0] blkoff;
    logic [DBYT_W-1:0] bytoff;  // always zero, word accesses only
  } dcachef_t;

  // one cache line as stored in a way, 92 bits
  typedef struct packed {
    logic [DTAG_W-1:0]        tag;
    word_t [2**DBLK_W-1:0]    data;   // data[0] is the even word
    logic                     valid;
    logic                     dirty;  // differs from memory, needs writeback
  } dframe_t;

endpackage

`default_nettype wire
